/* build.f */
+incdir+hdl
hdl/muldiv_pkg.sv
hdl/int_multiplier.sv
hdl/int_divider.sv
hdl/muldiv_unit.sv
test/muldiv_properties.sv
test/muldiv_tb.sv

/* Makefile */
TOP := muldiv_tb
BIN := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

/* test/muldiv_tb.sv */
// testbench for the multiply/divide unit with LCG stimulus and a reference model
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_params.svh"

module muldiv_tb
	import muldiv_pkg::*;
();

	localparam int NUM_OPS        = 200 + 200 + 8 + 1;
	localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + 100; // reset and idle margin

	logic       clk_i;
	logic       rst_i;
	logic       start_i;
	muldiv_op_t op_i;
	word_t      rs1_i;
	word_t      rs2_i;
	word_t      result_o;
	logic       done_o;
	logic       busy_o;

	logic [31:0] rng_state = 32'h8ec3_2f2d;
	int          cycle_count = 0;
	int          error_count = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_start_errors = 0;

	muldiv_unit dut_i (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.start_i  (start_i),
		.op_i     (op_i),
		.rs1_i    (rs1_i),
		.rs2_i    (rs2_i),
		.result_o (result_o),
		.done_o   (done_o),
		.busy_o   (busy_o)
	);

	initial clk_i = 1'b0;
	always #20 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// expected result from the M-extension rules
	function automatic word_t model_result(input muldiv_op_t op, input word_t a, input word_t b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [63:0]        ua;
		logic [63:0]        ub;
		logic [63:0]        prod;
		logic               ovf;
		sa   = {{`MD_XLEN{a[`MD_XLEN-1]}}, a};
		sb   = {{`MD_XLEN{b[`MD_XLEN-1]}}, b};
		ua   = {32'd0, a};
		ub   = {32'd0, b};
		ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		prod = (op == OP_MULHU) ? ua * ub : (op == OP_MULHSU) ? sa * ub : sa * sb;
		case (op)
			OP_MUL:  return prod[31:0];
			OP_DIV:  return (b == '0) ? '1 : ovf ? a : word_t'(sa / sb);
			OP_DIVU: return (b == '0) ? '1 : word_t'(ua / ub);
			OP_REM:  return (b == '0) ? a : ovf ? '0 : word_t'(sa % sb);
			OP_REMU: return (b == '0) ? a : word_t'(ua % ub);
			default: return prod[63:32]; // high product word
		endcase
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			error_count++;
			$display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			error_count++;
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic fail(input string what);
		error_count++;
		$display("%s", what);
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = error_count - test_start_errors;
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("test %-18s %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
		test_start_errors = error_count;
	endtask

	// one operation, optionally with a second strobe issued while busy
	task automatic run_op(input muldiv_op_t op, input word_t a, input word_t b, input bit poke);
		word_t exp;
		int    latency;
		int    cycles;
		string tag;
		exp     = model_result(op, a, b);
		latency = (op >= OP_DIV) ? `MD_DIV_ITER + 4 : 4;
		tag     = $sformatf("result_o for %s 0x%08h, 0x%08h", op.name(), a, b);
		@(posedge clk_i);
		#2;
		start_i = 1'b1;
		op_i    = op;
		rs1_i   = a;
		rs2_i   = b;
		cycles  = 0;
		do begin
			@(posedge clk_i);
			#2;
			cycles++;
			start_i = poke && (cycles == 3);
			if (start_i) begin
				op_i  = OP_MUL;
				rs1_i = ~a;
				rs2_i = b + 32'd1;
			end
			if (!done_o) begin
				check_flag("busy_o", busy_o, 1'b1);
			end
		end while (!done_o && cycles < latency + 8);
		if (!done_o) begin
			fail($sformatf("done_o never came for %s", op.name()));
		end else begin
			if (cycles != latency) begin
				fail($sformatf("done_o came %0d cycles after start of %s, expected %0d",
					cycles, op.name(), latency));
			end
			check_word(tag, result_o, exp);
			check_flag("busy_o", busy_o, 1'b0);
		end
		@(posedge clk_i);
		#2;
		check_flag("done_o", done_o, 1'b0);
	endtask

	initial begin
		word_t       a;
		word_t       b;
		logic [31:0] r;
		int          extra;
		start_i = 1'b0;
		op_i    = OP_MUL;
		rs1_i   = '0;
		rs2_i   = '0;
		rst_i   = 1'b1;
		repeat (10) @(posedge clk_i);
		#2;
		rst_i = 1'b0;
		check_flag("busy_o", busy_o, 1'b0);
		check_flag("done_o", done_o, 1'b0);
		check_word("result_o", result_o, '0);
		end_test("reset state");

		repeat (200) begin
			r = lcg_next();
			run_op(muldiv_op_t'({1'b0, r[1:0]}), lcg_next(), lcg_next(), 1'b0);
		end
		end_test("random multiply");

		repeat (200) begin
			r = lcg_next();
			a = lcg_next();
			b = lcg_next() >> r[6:2]; // spread divisor magnitudes
			if (r[7]) begin
				b = -b;
			end
			run_op(muldiv_op_t'({1'b1, r[1:0]}), a, b, 1'b0);
		end
		end_test("random divide");

		for (int k = 4; k < 8; k++) begin
			run_op(muldiv_op_t'(k[2:0]), lcg_next(), '0, 1'b0);
			run_op(muldiv_op_t'(k[2:0]), 32'h8000_0000, 32'hffff_ffff, 1'b0);
		end
		end_test("divide edge cases");

		run_op(OP_DIV, 32'hc3a5_0f17, 32'h0000_0b2d, 1'b1);
		extra = 0;
		repeat (`MD_DIV_ITER + 8) begin
			@(posedge clk_i);
			#2;
			if (done_o) begin
				extra++;
			end
			check_flag("busy_o", busy_o, 1'b0);
		end
		if (extra != 0) begin
			fail("done_o pulsed again after a start strobe issued while busy");
		end
		end_test("start while busy");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* test/muldiv_properties.sv */
// concurrent assertions on the done pulse, busy level and result of the unit
`timescale 1ns/1ps
`default_nettype none

module muldiv_properties
	import muldiv_pkg::*;
(
	input logic  clk_i,
	input logic  rst_i,
	input logic  done_i,
	input logic  busy_i,
	input word_t result_i
);

	// done is a single-cycle pulse
	done_single: assert property (@(posedge clk_i) disable iff (rst_i) done_i |=> !done_i)
		else $error("done_o high for two cycles in a row");

	busy_clear_on_done: assert property (@(posedge clk_i) disable iff (rst_i) done_i |-> !busy_i)
		else $error("busy_o high together with done_o");

	result_known: assert property (@(posedge clk_i) disable iff (rst_i)
		done_i |-> !$isunknown(result_i))
		else $error("result_o has unknown bits while done_o is high");

endmodule

bind muldiv_unit muldiv_properties props_i (
	.clk_i    (clk_i),
	.rst_i    (rst_i),
	.done_i   (done_o),
	.busy_i   (busy_o),
	.result_i (result_o)
);

`default_nettype wire

/* hdl/muldiv_unit.sv */
// multiply/divide unit top level with operation dispatch and result hold
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit
	import muldiv_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       start_i,
	input  muldiv_op_t op_i,
	input  word_t      rs1_i,
	input  word_t      rs2_i,
	output word_t      result_o,
	output logic       done_o,
	output logic       busy_o
);

	logic       accept;
	logic       engine_done;

	// accepted operation, held for the engines
	muldiv_op_t op_r;
	word_t      rs1_r;
	word_t      rs2_r;

	logic       mul_start_r;
	logic       div_start_r;

	word_t      mul_product;
	logic       mul_done;
	word_t      div_result;
	logic       div_done;

	assign accept      = start_i & ~busy_o; // strobes while busy are dropped
	assign engine_done = mul_done | div_done;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_o      <= 1'b0;
			done_o      <= 1'b0;
			result_o    <= '0;
			mul_start_r <= 1'b0;
			div_start_r <= 1'b0;
		end else begin
			mul_start_r <= accept & ~is_div_op(op_i);
			div_start_r <= accept & is_div_op(op_i);
			done_o      <= engine_done;

			if (accept) begin
				busy_o <= 1'b1;
			end else if (engine_done) begin
				busy_o <= 1'b0; // drops with done_o
			end

			if (mul_done) begin
				result_o <= mul_product;
			end else if (div_done) begin
				result_o <= div_result;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			op_r  <= op_i;
			rs1_r <= rs1_i;
			rs2_r <= rs2_i;
		end
	end

	// both engines see the operands, only the started one captures them
	int_multiplier mul_i (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.start_i   (mul_start_r),
		.op_i      (op_r),
		.a_i       (rs1_r),
		.b_i       (rs2_r),
		.product_o (mul_product),
		.done_o    (mul_done)
	);

	int_divider div_i (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.start_i    (div_start_r),
		.op_i       (op_r),
		.dividend_i (rs1_r),
		.divisor_i  (rs2_r),
		.result_o   (div_result),
		.done_o     (div_done)
	);

endmodule

`default_nettype wire

/* hdl/int_divider.sv */
// iterative restoring divider for div, divu, rem and remu
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_params.svh"

module int_divider
	import muldiv_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       start_i,
	input  muldiv_op_t op_i,
	input  word_t      dividend_i,
	input  word_t      divisor_i,
	output word_t      result_o,
	output logic       done_o
);

	localparam int MSB   = `MD_XLEN - 1;
	localparam int CNT_W = `MD_DIV_ITER + 2; // load, iterations, sign fix

	// one-hot step counter, bit 0 is the load state
	logic [CNT_W-1:0] cnt_r;

	muldiv_op_t op_r;
	logic       neg_quo_r;
	logic       neg_rem_r;
	logic       div_zero_r;
	logic       ovf_r;
	word_t      dividend_r; // kept as given, for the edge cases
	word_t      divisor_r;  // magnitude
	word_t      quo_r;      // dividend shifts out, quotient shifts in
	word_t      rem_r;

	logic       signed_op;
	logic       a_neg;
	logic       b_neg;
	word_t      a_mag;
	word_t      b_mag;
	logic       ovf_in;

	logic [`MD_XLEN:0]   shifted;
	logic [`MD_XLEN+1:0] trial;
	logic                q_bit;
	word_t               rem_next;

	word_t      quo_fix;
	word_t      rem_fix;
	word_t      fix_result;

	// load cycle, strip signs for the signed forms
	always_comb begin
		signed_op = (op_i == OP_DIV) || (op_i == OP_REM);
		a_neg     = signed_op & dividend_i[MSB];
		b_neg     = signed_op & divisor_i[MSB];
		a_mag     = a_neg ? (~dividend_i + 1'b1) : dividend_i;
		b_mag     = b_neg ? (~divisor_i + 1'b1) : divisor_i;
		// most negative value over minus one
		ovf_in    = signed_op && (dividend_i == {1'b1, {MSB{1'b0}}}) && (&divisor_i);
	end

	// one shift-subtract step
	always_comb begin
		shifted  = {rem_r, quo_r[MSB]};
		trial    = {1'b0, shifted} - {2'b00, divisor_r};
		q_bit    = ~trial[`MD_XLEN+1];
		rem_next = q_bit ? trial[MSB:0] : shifted[MSB:0]; // restore on borrow
	end

	// sign fix and architectural edge cases
	always_comb begin
		quo_fix = neg_quo_r ? (~quo_r + 1'b1) : quo_r;
		rem_fix = neg_rem_r ? (~rem_r + 1'b1) : rem_r; // remainder follows dividend

		if (div_zero_r) begin
			quo_fix = '1;
			rem_fix = dividend_r;
		end else if (ovf_r) begin
			quo_fix = dividend_r;
			rem_fix = '0;
		end

		if ((op_r == OP_REM) || (op_r == OP_REMU)) begin
			fix_result = rem_fix;
		end else begin
			fix_result = quo_fix;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt_r  <= CNT_W'(1);
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (cnt_r[0]) begin
				if (start_i) begin
					cnt_r <= cnt_r << 1;
				end
			end else if (cnt_r[CNT_W-1]) begin
				cnt_r  <= CNT_W'(1); // back to load
				done_o <= 1'b1;
			end else begin
				cnt_r <= cnt_r << 1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (cnt_r[0]) begin
			if (start_i) begin
				op_r       <= op_i;
				dividend_r <= dividend_i;
				divisor_r  <= b_mag;
				quo_r      <= a_mag;
				rem_r      <= '0;
				neg_quo_r  <= a_neg ^ b_neg;
				neg_rem_r  <= a_neg;
				div_zero_r <= (divisor_i == '0);
				ovf_r      <= ovf_in;
			end
		end else if (cnt_r[CNT_W-1]) begin
			result_o <= fix_result;
		end else begin
			quo_r <= {quo_r[MSB-1:0], q_bit};
			rem_r <= rem_next;
		end
	end

endmodule

`default_nettype wire

/* hdl/int_multiplier.sv */
// two-stage multiplier returning the low or high product word
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_params.svh"

module int_multiplier
	import muldiv_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       start_i,
	input  muldiv_op_t op_i,
	input  word_t      a_i,
	input  word_t      b_i,
	output word_t      product_o,
	output logic       done_o
);

	localparam int MSB = `MD_XLEN - 1;

	logic a_signed;
	logic b_signed;

	// stage one
	logic signed [`MD_XLEN:0] a_ext_r;
	logic signed [`MD_XLEN:0] b_ext_r;
	logic                     hi_sel_r;
	logic                     stage1_vld_r;

	// stage two
	logic signed [2*`MD_XLEN+1:0] prod_full;

	assign a_signed = (op_i == OP_MULH) || (op_i == OP_MULHSU);
	assign b_signed = (op_i == OP_MULH); // mulhsu keeps b unsigned

	assign prod_full = a_ext_r * b_ext_r;

	// done bit travels with the data
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			stage1_vld_r <= 1'b0;
			done_o       <= 1'b0;
		end else begin
			stage1_vld_r <= start_i;
			done_o       <= stage1_vld_r;
		end
	end

	always_ff @(posedge clk_i) begin
		if (start_i) begin
			a_ext_r  <= {a_signed & a_i[MSB], a_i};
			b_ext_r  <= {b_signed & b_i[MSB], b_i};
			hi_sel_r <= (op_i != OP_MUL);
		end
	end

	always_ff @(posedge clk_i) begin
		if (stage1_vld_r) begin
			if (hi_sel_r) begin
				product_o <= prod_full[2*`MD_XLEN-1:`MD_XLEN];
			end else begin
				product_o <= prod_full[MSB:0];
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/muldiv_pkg.sv */
// operation encoding, data word type and operation classifier
`default_nettype none

`include "muldiv_params.svh"

package muldiv_pkg;

	// msb set means the op runs on the divider
	typedef enum logic [2:0] {
		OP_MUL    = 3'd0,
		OP_MULH   = 3'd1,
		OP_MULHSU = 3'd2,
		OP_MULHU  = 3'd3,
		OP_DIV    = 3'd4,
		OP_DIVU   = 3'd5,
		OP_REM    = 3'd6,
		OP_REMU   = 3'd7
	} muldiv_op_t;

	typedef logic [`MD_XLEN-1:0] word_t;

	function automatic logic is_div_op(input muldiv_op_t op);
		logic [2:0] code;
		code = op;
		return code[2];
	endfunction

endpackage

`default_nettype wire

/* hdl/muldiv_params.svh */
// data width and divider iteration count for the multiply/divide unit
`ifndef MULDIV_PARAMS_SVH
`define MULDIV_PARAMS_SVH

// operand and result width
`define MD_XLEN 32

// quotient bits produced by the divider, one per iteration
`define MD_DIV_ITER `MD_XLEN

`endif
